// File: Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - .
    files:
      - rv_exec_pkg.sv
      - rv_exec_issue.sv
      - rv_exec_alu.sv
      - rv_exec_result.sv
      - rv_exec_top.sv
      - target: simulation
        files:
          - rv_exec_tb.sv

// File: rv_exec.f
+incdir+.
rv_exec_pkg.sv
rv_exec_issue.sv
rv_exec_alu.sv
rv_exec_result.sv
rv_exec_top.sv
rv_exec_tb.sv

// File: rv_exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_alu
  import rv_exec_pkg::*;
(
  input  exec_req_t  req_i,
  input  exec_ctrl_t ctrl_i,
  output exec_resp_t resp_o
);

  logic [`RV_XLEN-1:0]    adder_in2;
  logic [`RV_XLEN-1:0]    adder_res;
  logic                   adder_cout;
  logic [`RV_XLEN-1:0]    addw_res;
  logic                   lt_signed;
  logic                   lt_unsigned;
  logic                   equal;
  logic [`RV_SHAMT_W-1:0] shamt;
  logic [`RV_XLEN-1:0]    sll_res;
  logic [`RV_XLEN-1:0]    srl_res;
  logic [`RV_XLEN-1:0]    sra_res;
  logic [`RV_XLEN-1:0]    result;
  logic                   cond_ok;
  logic                   jump_taken;
  logic                   is_ls;
  ls_info_t               ls_info;

  // shared adder, subtract is op1 + ~op2 + 1
  assign adder_in2 = ctrl_i.sub ? ~req_i.op2 : req_i.op2;
  assign {adder_cout, adder_res} = {1'b0, req_i.op1} + {1'b0, adder_in2}
                                 + {{`RV_XLEN{1'b0}}, ctrl_i.sub};

  // word forms keep the low half, sign-extended
  assign addw_res = {{(`RV_XLEN-32){adder_res[31]}}, adder_res[31:0]};

  // signs differ: op1 negative wins; signs equal: difference sign decides
  assign lt_signed = (req_i.op1[`RV_XLEN-1] & ~req_i.op2[`RV_XLEN-1])
                   | (~(req_i.op1[`RV_XLEN-1] ^ req_i.op2[`RV_XLEN-1])
                      & adder_res[`RV_XLEN-1]);
  // no borrow out means op1 >= op2
  assign lt_unsigned = ~adder_cout;
  assign equal       = ~|adder_res;

  assign shamt   = req_i.op2[`RV_SHAMT_W-1:0];
  assign sll_res = req_i.op1 << shamt;
  assign srl_res = req_i.op1 >> shamt;
  assign sra_res = $signed(req_i.op1) >>> shamt;

  always_comb begin
    case (ctrl_i.sel)
      SEL_ADD:  result = adder_res;
      SEL_ADDW: result = addw_res;
      SEL_SLL:  result = sll_res;
      SEL_SRL:  result = srl_res;
      SEL_SRA:  result = sra_res;
      SEL_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      SEL_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      SEL_XOR:  result = req_i.op1 ^ req_i.op2;
      SEL_OR:   result = req_i.op1 | req_i.op2;
      SEL_AND:  result = req_i.op1 & req_i.op2;
      // upper immediate is already placed in op2
      SEL_LUI:  result = req_i.op2;
      default:  result = '0;
    endcase
  end

  // branch condition against the compare flags
  always_comb begin
    case (ctrl_i.br_cond)
      JAL, JALR: cond_ok = 1'b1;
      BEQ:       cond_ok = equal;
      BNE:       cond_ok = ~equal;
      BLT:       cond_ok = lt_signed;
      BGE:       cond_ok = ~lt_signed;
      BLTU:      cond_ok = lt_unsigned;
      BGEU:      cond_ok = ~lt_unsigned;
      default:   cond_ok = 1'b0;
    endcase
  end

  assign jump_taken = (ctrl_i.cls == CLS_BJP) && cond_ok;

  // memory side info, all zero outside the LS class
  assign is_ls               = (ctrl_i.cls == CLS_LS);
  assign ls_info.load        = is_ls && (req_i.op == LOAD);
  assign ls_info.store       = is_ls && (req_i.op == STORE);
  assign ls_info.is_unsigned = is_ls && req_i.ls_unsigned;
  assign ls_info.size        = is_ls ? req_i.ls_size : LS_BYTE;

  always_comb begin
    resp_o.rd_wr_en   = req_i.rd_wr_en;
    resp_o.rd_idx     = req_i.rd_idx;
    resp_o.result     = result;
    resp_o.jump_taken = jump_taken;
    // target adder runs for every packet
    resp_o.jump_addr  = req_i.jp_base + req_i.jp_offs;
    resp_o.ls_info    = ls_info;
    resp_o.store_data = ls_info.store ? req_i.store_data : '0;
  end

endmodule

`default_nettype wire

// File: rv_exec_consts.svh
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// integer register width, fixed by RV64
`define RV_XLEN 64

// destination register index, 32 registers
`define RV_REG_IDX_W 5

// shift amount field, log2 of RV_XLEN
`define RV_SHAMT_W 6

`endif

// File: rv_exec_issue.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_issue
  import rv_exec_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  exec_req_t  req_i,
  output logic       iss_valid_o,
  input  logic       iss_ready_i,
  output exec_req_t  iss_req_o,
  output exec_ctrl_t iss_ctrl_o
);

  logic       valid_q;
  exec_req_t  req_q;
  exec_ctrl_t dec;

  // accept when empty or when the held packet moves on this cycle
  assign req_ready_o = ~valid_q | iss_ready_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  // opcode to execute controls, from the held packet
  always_comb begin
    dec.cls     = CLS_ALU;
    dec.sub     = 1'b0;
    dec.sel     = SEL_ADD;
    dec.br_cond = ADD;
    case (req_q.op)
      SUB: dec.sub = 1'b1;
      ADDW: dec.sel = SEL_ADDW;
      SUBW: begin
        dec.sel = SEL_ADDW;
        dec.sub = 1'b1;
      end
      SLL: dec.sel = SEL_SLL;
      SRL: dec.sel = SEL_SRL;
      SRA: dec.sel = SEL_SRA;
      SLT: begin
        dec.sel = SEL_SLT;
        dec.sub = 1'b1;
      end
      SLTU: begin
        dec.sel = SEL_SLTU;
        dec.sub = 1'b1;
      end
      XOR: dec.sel = SEL_XOR;
      OR: dec.sel = SEL_OR;
      AND: dec.sel = SEL_AND;
      LUI: dec.sel = SEL_LUI;
      // link value comes out of the adder
      JAL, JALR: begin
        dec.cls     = CLS_BJP;
        dec.br_cond = req_q.op;
      end
      // compare through the subtracting adder
      BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
        dec.cls     = CLS_BJP;
        dec.sub     = 1'b1;
        dec.br_cond = req_q.op;
      end
      // effective address from the adder
      LOAD, STORE: dec.cls = CLS_LS;
      default: dec.sel = SEL_ADD;
    endcase
  end

  assign iss_valid_o = valid_q;
  assign iss_req_o   = req_q;
  assign iss_ctrl_o  = dec;

  // a stalled packet must not change under the downstream stage
  a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
    iss_valid_o && !iss_ready_i |=> iss_valid_o && $stable(iss_req_o));

endmodule

`default_nettype wire

// File: rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_consts.svh"

package rv_exec_pkg;

  // execute opcodes, already decoded from the instruction word
  typedef enum logic [4:0] {
    ADD, SUB, ADDW, SUBW,
    SLL, SRL, SRA,
    SLT, SLTU,
    XOR, OR, AND,
    LUI,
    JAL, JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    LOAD, STORE
  } exec_op_e;

  typedef enum logic [1:0] {
    CLS_ALU,
    CLS_BJP,
    CLS_LS
  } exec_class_e;

  // which datapath result goes to the write-back value
  typedef enum logic [3:0] {
    SEL_ADD, SEL_ADDW,
    SEL_SLL, SEL_SRL, SEL_SRA,
    SEL_SLT, SEL_SLTU,
    SEL_XOR, SEL_OR, SEL_AND,
    SEL_LUI
  } res_sel_e;

  typedef enum logic [1:0] {
    LS_BYTE,
    LS_HALF,
    LS_WORD,
    LS_DWORD
  } ls_size_e;

  typedef struct packed {
    exec_op_e                 op;
    logic                     rd_wr_en;
    logic [`RV_REG_IDX_W-1:0] rd_idx;
    logic [`RV_XLEN-1:0]      op1;
    logic [`RV_XLEN-1:0]      op2;
    logic [`RV_XLEN-1:0]      jp_base;
    logic [`RV_XLEN-1:0]      jp_offs;
    logic [`RV_XLEN-1:0]      store_data;
    ls_size_e                 ls_size;
    logic                     ls_unsigned;
  } exec_req_t;

  typedef struct packed {
    exec_class_e cls;
    logic        sub;
    res_sel_e    sel;
    exec_op_e    br_cond;
  } exec_ctrl_t;

  typedef struct packed {
    logic     load;
    logic     store;
    logic     is_unsigned;
    ls_size_e size;
  } ls_info_t;

  typedef struct packed {
    logic                     rd_wr_en;
    logic [`RV_REG_IDX_W-1:0] rd_idx;
    logic [`RV_XLEN-1:0]      result;
    logic                     jump_taken;
    logic [`RV_XLEN-1:0]      jump_addr;
    ls_info_t                 ls_info;
    logic [`RV_XLEN-1:0]      store_data;
  } exec_resp_t;

endpackage

`default_nettype wire

// File: rv_exec_result.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_result
  import rv_exec_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  exec_resp_t in_resp_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output exec_resp_t resp_o
);

  logic       valid_q;
  exec_resp_t resp_q;

  // load when empty or when the current response leaves
  assign in_ready_o = ~valid_q | resp_ready_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      resp_q <= in_resp_i;
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_o       = resp_q;

  // no withdrawal of a pending response
  a_valid_hold: assert property (@(posedge clk) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o);

  // decode and datapath never flag both memory directions
  a_ls_onehot: assert property (@(posedge clk) disable iff (reset_i)
    resp_valid_o |-> !(resp_o.ls_info.load && resp_o.ls_info.store));

endmodule

`default_nettype wire

// File: rv_exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_consts.svh"

module rv_exec_tb
  import rv_exec_pkg::*;
();

  localparam int MAX_ROWS = 40;
  localparam logic [`RV_XLEN-1:0] ALL1 = '1;
  localparam logic [`RV_XLEN-1:0] MIN2 = {{(`RV_XLEN-1){1'b1}}, 1'b0};
  localparam logic [`RV_XLEN-1:0] MSB  = {1'b1, {(`RV_XLEN-1){1'b0}}};
  localparam ls_info_t NO_LS = '0;

  logic        clk;
  logic        reset_i;
  logic        req_valid_i;
  logic        req_ready_o;
  exec_req_t   req_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  exec_resp_t  resp_o;

  exec_req_t   req_tab [MAX_ROWS];
  exec_resp_t  exp_tab [MAX_ROWS];
  int          n_rows = 0;
  int          sent = 0;
  int          rcv = 0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic        timed_out = 1'b0;
  logic        xfer;
  logic [15:0] lfsr = 16'd70;

  rv_exec_top UUT (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_o       (resp_o)
  );

  always #2 clk = ~clk;

  // galois form, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic check_val(input string name, input logic [`RV_XLEN-1:0] exp_v,
                           input logic [`RV_XLEN-1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  // one table row; target adder inputs and store data vary with the row number
  task automatic add_row(input exec_op_e op, input logic [`RV_XLEN-1:0] a,
                         input logic [`RV_XLEN-1:0] b, input logic [`RV_XLEN-1:0] res,
                         input logic jmp, input ls_info_t ls);
    exec_req_t  rq;
    exec_resp_t ex;
    logic       is_ls;
    is_ls          = ls.load | ls.store;
    rq.op          = op;
    rq.rd_wr_en    = n_rows[0];
    rq.rd_idx      = n_rows[4:0];
    rq.op1         = a;
    rq.op2         = b;
    rq.jp_base     = 64'h1000 + (n_rows << 8);
    rq.jp_offs     = 64'h20 + n_rows;
    rq.store_data  = {32'hDEAD_BEEF, 32'(n_rows)};
    // non-memory rows carry junk size bits that must not leak out
    rq.ls_size     = is_ls ? ls.size : LS_WORD;
    rq.ls_unsigned = is_ls ? ls.is_unsigned : 1'b1;
    ex.rd_wr_en    = rq.rd_wr_en;
    ex.rd_idx      = rq.rd_idx;
    ex.result      = res;
    ex.jump_taken  = jmp;
    // 0x1000 + 0x20, then 0x100 + 1 more for every row
    ex.jump_addr   = 64'h1020 + 64'h101 * n_rows;
    ex.ls_info     = ls;
    ex.store_data  = ls.store ? rq.store_data : '0;
    req_tab[n_rows] = rq;
    exp_tab[n_rows] = ex;
    n_rows++;
  endtask

  task automatic build_table();
    add_row(ADD, ALL1, 64'd1, 64'd0, 1'b0, NO_LS);
    add_row(SUB, 64'd3, 64'd5, MIN2, 1'b0, NO_LS);
    add_row(ADDW, 64'h7FFF_FFFF, 64'd1, 64'hFFFF_FFFF_8000_0000, 1'b0, NO_LS);
    add_row(SUBW, 64'd0, 64'd1, ALL1, 1'b0, NO_LS);
    add_row(XOR, 64'hF0F0, 64'hFF00, 64'h0FF0, 1'b0, NO_LS);
    add_row(OR, 64'hF0F0, 64'h0F0F, 64'hFFFF, 1'b0, NO_LS);
    add_row(AND, 64'hF0F0, 64'hFF00, 64'hF000, 1'b0, NO_LS);
    add_row(LUI, 64'd123, 64'hFFFF_FFFF_8000_0000, 64'hFFFF_FFFF_8000_0000, 1'b0, NO_LS);
    add_row(SLL, MSB | 64'd1, 64'd0, MSB | 64'd1, 1'b0, NO_LS);
    // only the low six bits of op2 count
    add_row(SLL, MSB | 64'd1, 64'h41, 64'd2, 1'b0, NO_LS);
    add_row(SLL, 64'd1, 64'd63, MSB, 1'b0, NO_LS);
    add_row(SRL, MSB | 64'd1, 64'd0, MSB | 64'd1, 1'b0, NO_LS);
    add_row(SRL, MSB, 64'd1, 64'h4000_0000_0000_0000, 1'b0, NO_LS);
    add_row(SRL, MSB, 64'd63, 64'd1, 1'b0, NO_LS);
    add_row(SRA, MSB | 64'd1, 64'd0, MSB | 64'd1, 1'b0, NO_LS);
    add_row(SRA, MSB, 64'd1, 64'hC000_0000_0000_0000, 1'b0, NO_LS);
    add_row(SRA, MSB, 64'd63, ALL1, 1'b0, NO_LS);
    add_row(SLT, ALL1, 64'd1, 64'd1, 1'b0, NO_LS);
    add_row(SLTU, ALL1, 64'd1, 64'd0, 1'b0, NO_LS);
    // branches leave op1 - op2 as the result
    add_row(BEQ, 64'd4, 64'd4, 64'd0, 1'b1, NO_LS);
    add_row(BEQ, 64'd4, 64'd5, ALL1, 1'b0, NO_LS);
    add_row(BNE, 64'd4, 64'd5, ALL1, 1'b1, NO_LS);
    add_row(BNE, 64'd4, 64'd4, 64'd0, 1'b0, NO_LS);
    add_row(BLT, ALL1, 64'd1, MIN2, 1'b1, NO_LS);
    add_row(BLT, 64'd1, ALL1, 64'd2, 1'b0, NO_LS);
    add_row(BGE, 64'd1, ALL1, 64'd2, 1'b1, NO_LS);
    add_row(BGE, ALL1, 64'd1, MIN2, 1'b0, NO_LS);
    add_row(BLTU, 64'd1, ALL1, 64'd2, 1'b1, NO_LS);
    add_row(BLTU, ALL1, 64'd1, MIN2, 1'b0, NO_LS);
    add_row(BGEU, ALL1, 64'd1, MIN2, 1'b1, NO_LS);
    add_row(BGEU, 64'd1, ALL1, 64'd2, 1'b0, NO_LS);
    add_row(JAL, 64'h2000, 64'd4, 64'h2004, 1'b1, NO_LS);
    add_row(JALR, 64'h2000, 64'd4, 64'h2004, 1'b1, NO_LS);
    add_row(LOAD, 64'h1000, 64'h10, 64'h1010, 1'b0, ls_info_t'({1'b1, 1'b0, 1'b1, LS_HALF}));
    add_row(STORE, 64'h1000, 64'hFFFF_FFFF_FFFF_FFF8, 64'h0FF8, 1'b0,
            ls_info_t'({1'b0, 1'b1, 1'b0, LS_DWORD}));
  endtask

  task automatic check_resp(input int i);
    check_val("resp_o.rd_wr_en", exp_tab[i].rd_wr_en, resp_o.rd_wr_en);
    check_val("resp_o.rd_idx", exp_tab[i].rd_idx, resp_o.rd_idx);
    check_val("resp_o.result", exp_tab[i].result, resp_o.result);
    check_val("resp_o.jump_taken", exp_tab[i].jump_taken, resp_o.jump_taken);
    check_val("resp_o.jump_addr", exp_tab[i].jump_addr, resp_o.jump_addr);
    check_val("resp_o.ls_info", exp_tab[i].ls_info, resp_o.ls_info);
    check_val("resp_o.store_data", exp_tab[i].store_data, resp_o.store_data);
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, responses %0d of %0d", checks, errors, rcv, n_rows);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // requests with random gaps, response ready at random
  always @(posedge clk) begin
    if (!reset_i) begin
      xfer = req_valid_i && req_ready_o;
      if (xfer) begin
        sent++;
      end
      lfsr = lfsr_step(lfsr);
      resp_ready_i <= lfsr[0];
      lfsr = lfsr_step(lfsr);
      if (!req_valid_i || xfer) begin
        if (sent < n_rows && lfsr[0]) begin
          req_valid_i <= 1'b1;
          req_i       <= req_tab[sent];
        end else begin
          req_valid_i <= 1'b0;
        end
      end
    end
  end

  // responses must come back in table order
  always @(posedge clk) begin
    if (!reset_i && resp_valid_o && resp_ready_i) begin
      if (rcv < n_rows) begin
        check_resp(rcv);
      end else begin
        errors++;
        $display("unexpected extra response at %0t after all %0d rows", $time, n_rows);
      end
      rcv <= rcv + 1;
    end
  end

  initial begin
    clk          = 1'b0;
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b0;
    build_table();
    for (int c = 0; c < 16; c++) begin
      @(posedge clk);
      // registers are known only after the first edge
      if (c > 0) begin
        check_val("resp_valid_o", 1'b0, resp_valid_o);
        check_val("req_ready_o", 1'b1, req_ready_o);
      end
    end
    reset_i <= 1'b0;
    while (rcv < n_rows && !timed_out) begin
      @(posedge clk);
      cycles++;
      if (cycles >= 8 * n_rows + 100) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      $display("timeout: only %0d of %0d responses after %0d cycles", rcv, n_rows, cycles);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: rv_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_exec_top
  import rv_exec_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  exec_req_t  req_i,
  output logic       resp_valid_o,
  input  logic       resp_ready_i,
  output exec_resp_t resp_o
);

  logic       iss_valid;
  logic       iss_ready;
  exec_req_t  iss_req;
  exec_ctrl_t iss_ctrl;
  exec_resp_t alu_resp;

  rv_exec_issue u_issue (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .iss_valid_o (iss_valid),
    .iss_ready_i (iss_ready),
    .iss_req_o   (iss_req),
    .iss_ctrl_o  (iss_ctrl)
  );

  rv_exec_alu u_alu (
    .req_i  (iss_req),
    .ctrl_i (iss_ctrl),
    .resp_o (alu_resp)
  );

  rv_exec_result u_result (
    .clk          (clk),
    .reset_i      (reset_i),
    .in_valid_i   (iss_valid),
    .in_ready_o   (iss_ready),
    .in_resp_i    (alu_resp),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_o       (resp_o)
  );

endmodule

`default_nettype wire
